// File: src/lock_cfg_pkg.sv
`default_nettype none

package lock_cfg_pkg;

    // Code and display geometry
    localparam int DIGIT_W        = 4;
    localparam int CODE_DIGITS    = 3;
    localparam int CODE_SLOTS     = 4;
    localparam int DISPLAY_DIGITS = 6;

    // Marker digits shared by keypad, code store and display
    localparam logic [DIGIT_W-1:0] DIGIT_TIMEOUT = 4'hE; // Keypad gave up waiting for digits
    localparam logic [DIGIT_W-1:0] DIGIT_CANCEL  = 4'hB; // Cancelled entry, also the blank digit
    localparam logic [DIGIT_W-1:0] DIGIT_FAIL    = 4'hA; // One failed attempt on the display
    localparam logic [DIGIT_W-1:0] DIGIT_EMPTY   = 4'hF; // Filler of an unused slot

    // Code held by slot 0 after reset, 1-2-3
    localparam logic [CODE_DIGITS*DIGIT_W-1:0] DEF_RESET_CODE_0 = {4'h1, 4'h2, 4'h3};

    // Timing defaults in clock cycles (1 kHz tick)
    localparam int unsigned DEF_DEBOUNCE_CYCLES   = 100;
    localparam int unsigned DEF_AUTO_LOCK_CYCLES  = 5000;
    localparam int unsigned DEF_OPEN_ALARM_CYCLES = 5000;
    localparam int unsigned DEF_BLOCK_CYCLES      = 30000;
    localparam int unsigned DEF_MAX_ATTEMPTS      = 5;

endpackage

`default_nettype wire

// File: src/lock_types_pkg.sv
`default_nettype none

package lock_types_pkg;
    import lock_cfg_pkg::*;

    typedef logic [DIGIT_W-1:0] digit_t;

    // Digit 0 sits in the top nibble, so 1-2-3 reads as 12'h123
    typedef logic [CODE_DIGITS*DIGIT_W-1:0] code_t;

    // Digit 0 in the top nibble is the leftmost digit shown
    typedef logic [DISPLAY_DIGITS*DIGIT_W-1:0] bcd_display_t;

    typedef logic [$clog2(CODE_SLOTS)-1:0] slot_idx_t;

    // Keypad entry, valid is a single cycle pulse
    typedef struct packed {
        logic  valid;
        code_t code;
    } keypad_entry_t;

    // Slot write port
    typedef struct packed {
        logic      valid;
        slot_idx_t slot;
        code_t     code;
    } code_load_t;

    // Answer of the code checker
    typedef struct packed {
        logic done;  // One cycle pulse
        logic match; // Valid with done
    } check_result_t;

endpackage

`default_nettype wire

// File: src/debounce_filter.sv
`default_nettype none
`timescale 1ns/10ps

module debounce_filter
    import lock_cfg_pkg::*;
#(
    parameter int unsigned DEBOUNCE_CYCLES = DEF_DEBOUNCE_CYCLES
) (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic press
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [CNT_W-1:0] held_cnt; // Consecutive cycles with the button down

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_cnt <= '0;
            press    <= 1'b0;
        end else begin
            press <= 1'b0;
            if (button) begin
                if (held_cnt != CNT_W'(DEBOUNCE_CYCLES))
                    held_cnt <= held_cnt + 1'b1; // Saturates once the press is long enough
            end else begin
                // Release, accept only a press held long enough
                press    <= (held_cnt == CNT_W'(DEBOUNCE_CYCLES));
                held_cnt <= '0;
            end
        end
    end

    // One press per release
    assert property (@(posedge clk) disable iff (rst) press |=> !press)
        else $error("debounce_filter: press held for more than one cycle");

endmodule

`default_nettype wire

// File: src/code_bank.sv
`default_nettype none
`timescale 1ns/10ps

module code_bank
    import lock_cfg_pkg::*, lock_types_pkg::*;
#(
    parameter code_t RESET_CODE_0 = DEF_RESET_CODE_0
) (
    input  logic          clk,
    input  logic          rst,
    input  code_load_t    load,
    input  logic          check_req,
    input  code_t         check_code,
    output check_result_t result
);

    localparam code_t     EMPTY_CODE = {CODE_DIGITS{DIGIT_EMPTY}};
    localparam slot_idx_t LAST_SLOT  = slot_idx_t'(CODE_SLOTS - 1);

    code_t     slots [CODE_SLOTS];
    code_t     code_q;   // Entered code under test
    slot_idx_t scan_idx; // Slot compared this cycle
    logic      busy;
    logic      slot_hit;
    logic [CODE_SLOTS-1:0] req_hist; // Recent requests, newest in bit 0

    // An empty slot never matches, even against an all F entry
    assign slot_hit = (slots[scan_idx] == code_q) && (slots[scan_idx] != EMPTY_CODE);

    // Answer in the cycle that compares the first hit or the last slot
    assign result.done  = busy && (slot_hit || scan_idx == LAST_SLOT);
    assign result.match = busy && slot_hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slots[0] <= RESET_CODE_0;
            for (int i = 1; i < CODE_SLOTS; i++)
                slots[i] <= EMPTY_CODE;
            busy     <= 1'b0;
            scan_idx <= '0;
        end else begin
            if (load.valid)
                slots[load.slot] <= load.code;

            if (check_req && !busy) begin
                busy     <= 1'b1;
                scan_idx <= '0; // Scan always starts at slot 0
            end else if (busy) begin
                if (result.done)
                    busy <= 1'b0; // First hit, or no slot matched
                else
                    scan_idx <= scan_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (check_req && !busy)
            code_q <= check_code;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            req_hist <= '0;
        else
            req_hist <= {req_hist[CODE_SLOTS-2:0], check_req};
    end

    // Every answer belongs to a request made within the last pass
    assert property (@(posedge clk) disable iff (rst) result.done |-> |req_hist)
        else $error("code_bank: done without a pending request");

    // Each accepted request is answered within one pass over the slots
    assert property (@(posedge clk) disable iff (rst)
        check_req && !busy |-> ##[1:CODE_SLOTS] result.done)
        else $error("code_bank: request not answered in time");

endmodule

`default_nettype wire

// File: src/attempt_guard.sv
`default_nettype none
`timescale 1ns/10ps

module attempt_guard
    import lock_cfg_pkg::*, lock_types_pkg::*;
#(
    parameter int unsigned MAX_ATTEMPTS = DEF_MAX_ATTEMPTS,
    parameter int unsigned BLOCK_CYCLES = DEF_BLOCK_CYCLES
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         attempt_fail,
    input  logic         attempt_ok,
    output logic         blocked,
    output bcd_display_t display
);

    localparam int CNT_W   = $clog2(MAX_ATTEMPTS + 1);
    localparam int BLOCK_W = $clog2(BLOCK_CYCLES + 1);

    logic [CNT_W-1:0]   fail_cnt;
    logic [BLOCK_W-1:0] block_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fail_cnt  <= '0;
            block_cnt <= '0;
            blocked   <= 1'b0;
        end else if (blocked) begin
            // Keypad locked out, failures are not counted
            if (block_cnt == BLOCK_W'(BLOCK_CYCLES - 1)) begin
                blocked  <= 1'b0;
                fail_cnt <= '0;
            end
            block_cnt <= block_cnt + 1'b1;
        end else if (fail_cnt == CNT_W'(MAX_ATTEMPTS)) begin
            blocked   <= 1'b1;
            block_cnt <= '0;
        end else if (attempt_ok) begin
            fail_cnt <= '0;
        end else if (attempt_fail) begin
            fail_cnt <= fail_cnt + 1'b1;
        end
    end

    // One A per failure from the left, all A while blocked
    always_comb begin
        for (int i = 0; i < DISPLAY_DIGITS; i++) begin
            if (blocked || (i < fail_cnt))
                display[(DISPLAY_DIGITS-1-i)*DIGIT_W +: DIGIT_W] = DIGIT_FAIL;
            else
                display[(DISPLAY_DIGITS-1-i)*DIGIT_W +: DIGIT_W] = DIGIT_CANCEL;
        end
    end

    assert property (@(posedge clk) disable iff (rst) fail_cnt <= MAX_ATTEMPTS)
        else $error("attempt_guard: failure count above limit");

endmodule

`default_nettype wire

// File: src/door_fsm.sv
`default_nettype none
`timescale 1ns/10ps

module door_fsm
    import lock_cfg_pkg::*, lock_types_pkg::*;
#(
    parameter int unsigned AUTO_LOCK_CYCLES  = DEF_AUTO_LOCK_CYCLES,
    parameter int unsigned OPEN_ALARM_CYCLES = DEF_OPEN_ALARM_CYCLES
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          door_open,
    input  logic          press,
    input  keypad_entry_t entry,
    input  logic          blocked,
    output logic          check_req,
    output code_t         check_code,
    input  check_result_t result,
    output logic          attempt_fail,
    output logic          attempt_ok,
    output logic          latch,
    output logic          beep
);

    localparam int unsigned TIMER_MAX =
        (AUTO_LOCK_CYCLES > OPEN_ALARM_CYCLES) ? AUTO_LOCK_CYCLES : OPEN_ALARM_CYCLES;
    localparam int TIMER_W = $clog2(TIMER_MAX + 1);

    typedef enum logic [2:0] {
        INIT,
        LOCKED,
        CHECKING,     // Waiting for the code checker
        TIMEOUT_BEEP,
        AJAR,         // Unlatched, door still closed
        OPEN,
        OPEN_ALARM,
        BLOCKED
    } door_state_t;

    door_state_t      state, state_next;
    logic [TIMER_W-1:0] timer; // Cycles spent in the current state
    digit_t           first_digit;
    logic             entry_code;

    assign first_digit = entry.code[$bits(code_t)-1 -: DIGIT_W];
    // Entry that starts a code check
    assign entry_code  = entry.valid && first_digit != DIGIT_TIMEOUT
                         && first_digit != DIGIT_CANCEL;

    always_comb begin
        state_next = state;
        case (state)
            INIT:         if (!door_open) state_next = LOCKED;
            LOCKED: begin
                if (blocked)
                    state_next = BLOCKED;
                else if (press)
                    state_next = AJAR;
                else if (entry.valid && first_digit == DIGIT_TIMEOUT)
                    state_next = TIMEOUT_BEEP;
                else if (entry_code)
                    state_next = CHECKING;
            end
            CHECKING:     if (result.done) state_next = result.match ? AJAR : LOCKED;
            TIMEOUT_BEEP: state_next = LOCKED;
            AJAR: begin
                if (door_open)
                    state_next = OPEN;
                else if (press || timer == TIMER_W'(AUTO_LOCK_CYCLES - 1))
                    state_next = LOCKED; // Inside press or auto lock
            end
            OPEN: begin
                if (!door_open)
                    state_next = AJAR;
                else if (timer == TIMER_W'(OPEN_ALARM_CYCLES - 1))
                    state_next = OPEN_ALARM;
            end
            OPEN_ALARM:   if (!door_open) state_next = AJAR;
            BLOCKED:      if (!blocked) state_next = LOCKED;
            default:      state_next = INIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= INIT;
            timer <= '0;
        end else begin
            state <= state_next;
            if (state_next != state)
                timer <= '0; // Restart on every state change
            else if (timer != TIMER_W'(TIMER_MAX))
                timer <= timer + 1'b1;
        end
    end

    // Request leaves with the transition into CHECKING
    assign check_req  = (state == LOCKED) && (state_next == CHECKING);
    assign check_code = entry.code;

    assign attempt_ok   = (state == CHECKING) && result.done && result.match;
    assign attempt_fail = (state == CHECKING) && result.done && !result.match;

    assign latch = (state == LOCKED) || (state == CHECKING)
                   || (state == TIMEOUT_BEEP) || (state == BLOCKED);
    assign beep  = (state == TIMEOUT_BEEP) || (state == OPEN_ALARM);

    // Timeout beep only right after a keypad entry, otherwise only the open alarm
    assert property (@(posedge clk) disable iff (rst)
        beep |-> (state == OPEN_ALARM) || (state == TIMEOUT_BEEP && $past(entry.valid)))
        else $error("door_fsm: beep outside of an alarm state");

endmodule

`default_nettype wire

// File: src/lock_top.sv
`default_nettype none
`timescale 1ns/10ps

module lock_top
    import lock_cfg_pkg::*, lock_types_pkg::*;
#(
    parameter int unsigned DEBOUNCE_CYCLES   = DEF_DEBOUNCE_CYCLES,
    parameter int unsigned AUTO_LOCK_CYCLES  = DEF_AUTO_LOCK_CYCLES,
    parameter int unsigned OPEN_ALARM_CYCLES = DEF_OPEN_ALARM_CYCLES,
    parameter int unsigned BLOCK_CYCLES      = DEF_BLOCK_CYCLES,
    parameter int unsigned MAX_ATTEMPTS      = DEF_MAX_ATTEMPTS,
    parameter code_t       RESET_CODE_0      = DEF_RESET_CODE_0
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          door_open,
    input  logic          inside_button,
    input  keypad_entry_t entry,
    input  code_load_t    load,
    output logic          latch,
    output logic          beep,
    output bcd_display_t  display
);

    logic          press;
    logic          check_req;
    code_t         check_code;
    check_result_t result;
    logic          attempt_fail;
    logic          attempt_ok;
    logic          blocked;

    debounce_filter #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_debounce (
        .clk(clk), .rst(rst), .button(inside_button), .press(press)
    );

    code_bank #(.RESET_CODE_0(RESET_CODE_0)) u_code_bank (
        .clk(clk), .rst(rst), .load(load),
        .check_req(check_req), .check_code(check_code), .result(result)
    );

    attempt_guard #(.MAX_ATTEMPTS(MAX_ATTEMPTS), .BLOCK_CYCLES(BLOCK_CYCLES)) u_guard (
        .clk(clk), .rst(rst), .attempt_fail(attempt_fail), .attempt_ok(attempt_ok),
        .blocked(blocked), .display(display)
    );

    door_fsm #(
        .AUTO_LOCK_CYCLES(AUTO_LOCK_CYCLES),
        .OPEN_ALARM_CYCLES(OPEN_ALARM_CYCLES)
    ) u_door_fsm (
        .clk(clk), .rst(rst), .door_open(door_open), .press(press), .entry(entry),
        .blocked(blocked), .check_req(check_req), .check_code(check_code),
        .result(result), .attempt_fail(attempt_fail), .attempt_ok(attempt_ok),
        .latch(latch), .beep(beep)
    );

endmodule

`default_nettype wire

// File: dv/lock_checker.sv
`default_nettype none
`timescale 1ns/10ps

module lock_checker
    import lock_types_pkg::*;
(
    input logic         clk,
    input logic         latch,
    input logic         beep,
    input bcd_display_t display
);

    int pass_count = 0;
    int fail_count = 0;

    function automatic logic outputs_match(input logic exp_latch, input logic exp_beep,
                                           input bcd_display_t exp_disp);
        return (latch === exp_latch) && (beep === exp_beep) && (display === exp_disp);
    endfunction

    // Polls on falling edges, where the DUT outputs are settled
    task automatic expect_outputs(input string name, input logic exp_latch,
                                  input logic exp_beep, input bcd_display_t exp_disp,
                                  input int budget);
        int   waited;
        logic hit;
        waited = 0;
        hit    = outputs_match(exp_latch, exp_beep, exp_disp);
        while (!hit && waited < budget) begin
            @(negedge clk);
            waited++;
            hit = outputs_match(exp_latch, exp_beep, exp_disp);
        end
        if (hit) begin
            pass_count++;
            $display("ok       %-20s settled after %0d cycles", name, waited);
        end else begin
            fail_count++;
            $write("Mismatch %s: expected latch=%b beep=%b display=%h, ",
                   name, exp_latch, exp_beep, exp_disp);
            $display("actual latch=%b beep=%b display=%h", latch, beep, display);
        end
    endtask

    task automatic report_counts();
        $display("Tests run %0d, passed %0d, failed %0d",
                 pass_count + fail_count, pass_count, fail_count);
    endtask

endmodule

`default_nettype wire

// File: dv/lock_tb.sv
`default_nettype none
`timescale 1ns/10ps

module lock_tb
    import lock_types_pkg::*;
;

    typedef enum {DO_ENTRY, DO_LOAD, DO_PRESS, DO_DOOR, DO_IDLE} action_t;

    // Display patterns, digit 0 leftmost
    localparam bcd_display_t SHOW_NONE = 24'hBBBBBB;
    localparam bcd_display_t SHOW_ONE  = 24'hABBBBB;
    localparam bcd_display_t SHOW_TWO  = 24'hAABBBB;
    localparam bcd_display_t SHOW_ALL  = 24'hAAAAAA; // Blocked
    localparam int WATCHDOG_CYCLES = 3000;

    logic          clk;
    logic          rst;
    logic          door_open;
    logic          inside_button;
    keypad_entry_t entry;
    code_load_t    load;
    logic          latch;
    logic          beep;
    bcd_display_t  display;

    // Stimulus table, one entry per row in each queue
    string         row_name[$];
    action_t       row_act[$];
    logic [15:0]   row_arg[$];
    logic          row_latch[$];
    logic          row_beep[$];
    bcd_display_t  row_disp[$];
    int            row_budget[$];

    lock_top #(
        .DEBOUNCE_CYCLES(4),
        .AUTO_LOCK_CYCLES(40),
        .OPEN_ALARM_CYCLES(30),
        .BLOCK_CYCLES(50),
        .MAX_ATTEMPTS(3)
    ) UUT (
        .clk(clk), .rst(rst), .door_open(door_open), .inside_button(inside_button),
        .entry(entry), .load(load), .latch(latch), .beep(beep), .display(display)
    );

    lock_checker u_checker (.clk(clk), .latch(latch), .beep(beep), .display(display));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic add_row(input string name, input action_t act, input logic [15:0] arg,
                           input logic exp_latch, input logic exp_beep,
                           input bcd_display_t exp_disp, input int budget);
        row_name.push_back(name);
        row_act.push_back(act);
        row_arg.push_back(arg);
        row_latch.push_back(exp_latch);
        row_beep.push_back(exp_beep);
        row_disp.push_back(exp_disp);
        row_budget.push_back(budget);
    endtask

    task automatic build_table();
        add_row("reset_lock",        DO_IDLE,  16'd1,    1'b1, 1'b0, SHOW_NONE, 5);
        add_row("match_slot0",       DO_ENTRY, 16'h0123, 1'b0, 1'b0, SHOW_NONE, 10);
        add_row("relock_press",      DO_PRESS, 16'd6,    1'b1, 1'b0, SHOW_NONE, 10);
        add_row("load_slot3",        DO_LOAD,  16'h3456, 1'b1, 1'b0, SHOW_NONE, 2);
        add_row("match_slot3",       DO_ENTRY, 16'h0456, 1'b0, 1'b0, SHOW_NONE, 12);
        add_row("relock_slot3",      DO_PRESS, 16'd6,    1'b1, 1'b0, SHOW_NONE, 10);
        add_row("fail_1",            DO_ENTRY, 16'h0999, 1'b1, 1'b0, SHOW_ONE,  12);
        add_row("fail_2",            DO_ENTRY, 16'h0999, 1'b1, 1'b0, SHOW_TWO,  12);
        add_row("fail_3_block",      DO_ENTRY, 16'h0999, 1'b1, 1'b0, SHOW_ALL,  12);
        add_row("blocked_ignore",    DO_ENTRY, 16'h8123, 1'b1, 1'b0, SHOW_ALL,  0);
        add_row("block_expire",      DO_IDLE,  16'd1,    1'b1, 1'b0, SHOW_NONE, 70);
        add_row("block_settle",      DO_IDLE,  16'd2,    1'b1, 1'b0, SHOW_NONE, 2);
        add_row("unlock_after_block", DO_ENTRY, 16'h0123, 1'b0, 1'b0, SHOW_NONE, 10);
        add_row("relock_after_block", DO_PRESS, 16'd6,   1'b1, 1'b0, SHOW_NONE, 10);
        add_row("timeout_beep",      DO_ENTRY, 16'h0E00, 1'b1, 1'b1, SHOW_NONE, 2);
        add_row("timeout_quiet",     DO_IDLE,  16'd1,    1'b1, 1'b0, SHOW_NONE, 0);
        add_row("short_press",       DO_PRESS, 16'h0502, 1'b1, 1'b0, SHOW_NONE, 0);
        add_row("long_press",        DO_PRESS, 16'd6,    1'b0, 1'b0, SHOW_NONE, 5);
        add_row("ajar_hold",         DO_IDLE,  16'd30,   1'b0, 1'b0, SHOW_NONE, 0);
        add_row("auto_lock",         DO_IDLE,  16'd1,    1'b1, 1'b0, SHOW_NONE, 50);
        add_row("unlock_for_open",   DO_ENTRY, 16'h0123, 1'b0, 1'b0, SHOW_NONE, 10);
        add_row("door_open",         DO_DOOR,  16'd1,    1'b0, 1'b0, SHOW_NONE, 3);
        add_row("open_alarm",        DO_IDLE,  16'd1,    1'b0, 1'b1, SHOW_NONE, 45);
        add_row("door_close",        DO_DOOR,  16'd0,    1'b0, 1'b0, SHOW_NONE, 3);
        add_row("relock_end",        DO_PRESS, 16'd6,    1'b1, 1'b0, SHOW_NONE, 10);
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic apply_action(input action_t act, input logic [15:0] arg);
        case (act)
            DO_ENTRY: begin
                entry.code  = arg[11:0];
                entry.valid = 1'b1;
                @(negedge clk);
                entry.valid = 1'b0; // Single cycle pulse
                repeat (arg[15:12]) @(negedge clk); // Settle cycles in the top nibble
            end
            DO_LOAD: begin
                load.slot  = arg[13:12];
                load.code  = arg[11:0];
                load.valid = 1'b1;
                @(negedge clk);
                load.valid = 1'b0;
            end
            DO_PRESS: begin
                inside_button = 1'b1;
                repeat (arg[7:0]) @(negedge clk); // Held cycles
                inside_button = 1'b0;
                repeat (arg[15:8]) @(negedge clk); // Cycles after release
            end
            DO_DOOR: begin
                door_open = arg[0];
                @(negedge clk);
            end
            default: repeat (arg) @(negedge clk);
        endcase
    endtask

    initial begin
        rst           = 1'b1;
        door_open     = 1'b0;
        inside_button = 1'b0;
        entry         = '0;
        load          = '0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < row_name.size(); i++) begin
            apply_action(row_act[i], row_arg[i]);
            u_checker.expect_outputs(row_name[i], row_latch[i], row_beep[i], row_disp[i],
                                     row_budget[i]);
        end
        u_checker.report_counts();
        if (u_checker.fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
src/lock_cfg_pkg.sv
src/lock_types_pkg.sv
src/debounce_filter.sv
src/code_bank.sv
src/attempt_guard.sv
src/door_fsm.sv
src/lock_top.sv
dv/lock_checker.sv
dv/lock_tb.sv
